/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0] FN3_ADD_SUB = 3'b000;
    localparam logic [2:0] FN3_SLL     = 3'b001;
    localparam logic [2:0] FN3_SLT     = 3'b010;
    localparam logic [2:0] FN3_SLTU    = 3'b011;
    localparam logic [2:0] FN3_XOR     = 3'b100;
    localparam logic [2:0] FN3_SRL_SRA = 3'b101;
    localparam logic [2:0] FN3_OR      = 3'b110;
    localparam logic [2:0] FN3_AND     = 3'b111;

    localparam logic [2:0] FN3_BEQ  = 3'b000;
    localparam logic [2:0] FN3_BNE  = 3'b001;
    localparam logic [2:0] FN3_BLT  = 3'b100;
    localparam logic [2:0] FN3_BGE  = 3'b101;
    localparam logic [2:0] FN3_BLTU = 3'b110;
    localparam logic [2:0] FN3_BGEU = 3'b111;

    localparam logic [2:0] FN3_LB  = 3'b000; // Also SB
    localparam logic [2:0] FN3_LH  = 3'b001; // Also SH
    localparam logic [2:0] FN3_LW  = 3'b010; // Also SW
    localparam logic [2:0] FN3_LBU = 3'b100;
    localparam logic [2:0] FN3_LHU = 3'b101;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    localparam instr_t NOP_INSTR = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

/* src/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B,
        ALU_BR_EQ,
        ALU_BR_NE,
        ALU_BR_LT,
        ALU_BR_GE,
        ALU_BR_LTU,
        ALU_BR_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        BRT_NONE,
        BRT_BR,
        BRT_JAL,
        BRT_JALR
    } br_type_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LOAD,
        WB_RET_ADDR
    } wb_sel_e;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } mem_size_e;

endpackage

/* src/control.sv */
module control (
    input  rv_isa_pkg::instr_t        instr,
    input  logic                      setup,
    output core_ctrl_pkg::alu_op_e    alu_op,
    output logic                      reg_we,
    output core_ctrl_pkg::br_type_e   br_type,
    output logic                      mem_we,
    output logic                      mem_re,
    output core_ctrl_pkg::mem_size_e  mem_size,
    output logic                      mem_signed,
    output logic                      op1_pc,
    output logic                      op2_reg,
    output core_ctrl_pkg::wb_sel_e    wb_sel,
    output logic                      fetch_en,
    output logic                      pc_load_first,
    output logic                      is_halt
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic       is_op, is_op_imm, is_load, is_store;
    logic       is_branch, is_jal, is_jalr, is_lui;
    logic       is_auipc, is_system;
    logic [2:0] fn3;
    logic       bit30;

    assign fn3   = instr.r.funct3;
    assign bit30 = instr.r.funct7[5];

    assign is_op     = instr.r.opcode == OPC_OP;
    assign is_op_imm = instr.r.opcode == OPC_OP_IMM;
    assign is_load   = instr.r.opcode == OPC_LOAD;
    assign is_store  = instr.r.opcode == OPC_STORE;
    assign is_branch = instr.r.opcode == OPC_BRANCH;
    assign is_jal    = instr.r.opcode == OPC_JAL;
    assign is_jalr   = instr.r.opcode == OPC_JALR;
    assign is_lui    = instr.r.opcode == OPC_LUI;
    assign is_auipc  = instr.r.opcode == OPC_AUIPC;
    assign is_system = instr.r.opcode == OPC_SYSTEM;

    always_comb begin
        alu_op = ALU_ADD; // Loads, stores, jumps, AUIPC
        if (is_op || is_op_imm) begin
            case (fn3)
                FN3_ADD_SUB: alu_op = (is_op && bit30) ? ALU_SUB : ALU_ADD;
                FN3_SLL:     alu_op = ALU_SLL;
                FN3_SLT:     alu_op = ALU_SLT;
                FN3_SLTU:    alu_op = ALU_SLTU;
                FN3_XOR:     alu_op = ALU_XOR;
                FN3_SRL_SRA: alu_op = bit30 ? ALU_SRA : ALU_SRL;
                FN3_OR:      alu_op = ALU_OR;
                FN3_AND:     alu_op = ALU_AND;
            endcase
        end else if (is_lui) begin
            alu_op = ALU_PASS_B;
        end else if (is_branch) begin
            case (fn3)
                FN3_BNE:  alu_op = ALU_BR_NE;
                FN3_BLT:  alu_op = ALU_BR_LT;
                FN3_BGE:  alu_op = ALU_BR_GE;
                FN3_BLTU: alu_op = ALU_BR_LTU;
                FN3_BGEU: alu_op = ALU_BR_GEU;
                default:  alu_op = ALU_BR_EQ;
            endcase
        end
    end

    always_comb begin
        case (fn3)
            FN3_LB, FN3_LBU: mem_size = SZ_BYTE;
            FN3_LH, FN3_LHU: mem_size = SZ_HALF;
            default:         mem_size = SZ_WORD;
        endcase
    end

    assign mem_signed = !(fn3 == FN3_LBU || fn3 == FN3_LHU);
    assign mem_we     = is_store;
    assign mem_re     = is_load;

    assign reg_we = is_op || is_op_imm || is_lui || is_auipc || is_jal || is_jalr || is_load;

    assign br_type = is_jal    ? BRT_JAL :
                     is_jalr   ? BRT_JALR :
                     is_branch ? BRT_BR : BRT_NONE;

    assign wb_sel = (is_jal || is_jalr)                       ? WB_RET_ADDR :
                    (is_op || is_op_imm || is_lui || is_auipc) ? WB_ALU :
                    is_load                                    ? WB_LOAD : WB_NONE;

    assign op1_pc  = is_auipc || is_jal;
    assign op2_reg = is_op || is_branch;

    assign fetch_en      = !setup;
    assign pc_load_first = setup; // Park PC while the host loads code
    assign is_halt       = is_system;

endmodule

/* src/alu.sv */
module alu (
    input  core_ctrl_pkg::alu_op_e op,
    input  logic [31:0]            a,
    input  logic [31:0]            b,
    output logic [31:0]            result,
    output logic                   taken
);
    import core_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_PASS_B: result = b;
            ALU_BR_EQ:  taken  = a == b;
            ALU_BR_NE:  taken  = a != b;
            ALU_BR_LT:  taken  = $signed(a) < $signed(b);
            ALU_BR_GE:  taken  = $signed(a) >= $signed(b);
            ALU_BR_LTU: taken  = a < b;
            ALU_BR_GEU: taken  = a >= b;
            default:    result = '0;
        endcase
    end

endmodule

/* src/lsu.sv */
module lsu (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     we,
    input  core_ctrl_pkg::mem_size_e size,
    input  logic                     signed_ld,
    input  logic [31:0]              addr,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata,
    output logic                     done,
    output logic                     m0_cyc,
    output logic                     m0_stb,
    output logic                     m0_we,
    output logic [31:0]              m0_adr,
    output logic [31:0]              m0_dat_w,
    output logic [3:0]               m0_sel,
    input  logic                     m0_ack,
    input  logic [31:0]              m0_dat_r
);
    import core_ctrl_pkg::*;

    mem_size_e   size_q;
    logic        signed_q;
    logic [1:0]  off_q;
    logic [31:0] lane_data;
    logic [31:0] ext_data;

    assign m0_stb    = m0_cyc;
    assign lane_data = m0_dat_r >> {off_q, 3'b000}; // Addressed byte down to bit 0

    always_comb begin
        case (size_q)
            SZ_BYTE: ext_data = {{24{signed_q & lane_data[7]}}, lane_data[7:0]};
            SZ_HALF: ext_data = {{16{signed_q & lane_data[15]}}, lane_data[15:0]};
            default: ext_data = m0_dat_r;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m0_cyc <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (start) begin
                m0_cyc <= 1'b1;
            end else if (m0_ack) begin
                m0_cyc <= 1'b0;
            end
            done <= m0_cyc & m0_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            m0_adr   <= {addr[31:2], 2'b00};
            m0_we    <= we;
            size_q   <= size;
            signed_q <= signed_ld;
            off_q    <= addr[1:0];
            case (size)
                SZ_BYTE: begin
                    m0_dat_w <= {4{wdata[7:0]}};
                    m0_sel   <= 4'b0001 << addr[1:0];
                end
                SZ_HALF: begin
                    m0_dat_w <= {2{wdata[15:0]}};
                    m0_sel   <= 4'b0011 << addr[1:0];
                end
                default: begin
                    m0_dat_w <= wdata;
                    m0_sel   <= 4'b1111;
                end
            endcase
        end
        if (m0_cyc && m0_ack) begin
            rdata <= ext_data;
        end
    end

endmodule

/* src/rv_core.sv */
module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     setup,
    output logic                     halt,
    output logic                     m1_cyc,
    output logic                     m1_stb,
    output logic                     m1_we,
    output logic [31:0]              m1_adr,
    output logic [31:0]              m1_dat_w,
    output logic [3:0]               m1_sel,
    input  logic                     m1_ack,
    input  logic [31:0]              m1_dat_r,
    output logic                     lsu_start,
    output logic                     lsu_we,
    output core_ctrl_pkg::mem_size_e lsu_size,
    output logic                     lsu_signed_ld,
    output logic [31:0]              lsu_addr,
    output logic [31:0]              lsu_wdata,
    input  logic [31:0]              lsu_rdata,
    input  logic                     lsu_done
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    typedef enum logic [2:0] {FETCH, EXEC, MEM, WB, HALT} state_e;

    state_e      state;
    logic [31:0] pc;
    instr_t      instr_q;
    logic [31:0] rf [1:31];
    logic [31:0] rs1_val, rs2_val;
    logic [31:0] imm;
    logic [31:0] op_a, op_b;
    logic [31:0] alu_res, alu_q;
    logic        alu_taken, taken_q;
    logic [31:0] pc_plus4, pc_imm;
    logic [31:0] next_pc, wb_data;

    alu_op_e     alu_op;
    br_type_e    br_type;
    wb_sel_e     wb_sel;
    logic        reg_we, mem_re, op1_pc, op2_reg;
    logic        fetch_en, pc_load_first, is_halt;

    control i_control (
        .instr         (instr_q),
        .setup         (setup),
        .alu_op        (alu_op),
        .reg_we        (reg_we),
        .br_type       (br_type),
        .mem_we        (lsu_we),
        .mem_re        (mem_re),
        .mem_size      (lsu_size),
        .mem_signed    (lsu_signed_ld),
        .op1_pc        (op1_pc),
        .op2_reg       (op2_reg),
        .wb_sel        (wb_sel),
        .fetch_en      (fetch_en),
        .pc_load_first (pc_load_first),
        .is_halt       (is_halt)
    );

    alu i_alu (
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_res),
        .taken  (alu_taken)
    );

    assign rs1_val = (instr_q.r.rs1 == 5'd0) ? 32'd0 : rf[instr_q.r.rs1];
    assign rs2_val = (instr_q.r.rs2 == 5'd0) ? 32'd0 : rf[instr_q.r.rs2];

    always_comb begin
        case (instr_q.r.opcode)
            OPC_STORE:  imm = {{20{instr_q[31]}}, instr_q.r.funct7, instr_q.r.rd};
            OPC_BRANCH: imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                               instr_q[30:25], instr_q[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {instr_q[31:12], 12'b0};
            OPC_JAL:    imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                               instr_q[20], instr_q[30:21], 1'b0};
            default:    imm = {{20{instr_q.i.imm12[11]}}, instr_q.i.imm12};
        endcase
    end

    assign op_a     = op1_pc ? pc : rs1_val;
    assign op_b     = op2_reg ? rs2_val : imm;
    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + imm; // Branch and JAL target

    always_comb begin
        case (br_type)
            BRT_BR:   next_pc = taken_q ? pc_imm : pc_plus4;
            BRT_JAL:  next_pc = pc_imm;
            BRT_JALR: next_pc = {alu_q[31:1], 1'b0};
            default:  next_pc = pc_plus4;
        endcase
        case (wb_sel)
            WB_LOAD:     wb_data = lsu_rdata;
            WB_RET_ADDR: wb_data = pc_plus4;
            default:     wb_data = alu_q;
        endcase
    end

    assign m1_stb    = m1_cyc;
    assign m1_we     = 1'b0;
    assign m1_adr    = pc;
    assign m1_dat_w  = '0;
    assign m1_sel    = 4'b1111;
    assign lsu_start = (state == EXEC) && !is_halt && (mem_re || lsu_we);
    assign lsu_addr  = alu_res;
    assign lsu_wdata = rs2_val;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= FETCH;
            pc      <= RESET_PC;
            instr_q <= NOP_INSTR;
            m1_cyc  <= 1'b0;
            halt    <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc_load_first && !m1_cyc) begin
                        pc <= RESET_PC;
                    end
                    if (m1_ack) begin
                        m1_cyc  <= 1'b0;
                        instr_q <= m1_dat_r;
                        state   <= EXEC;
                    end else if (fetch_en) begin
                        m1_cyc <= 1'b1;
                    end
                end
                EXEC: begin
                    if (is_halt) begin
                        halt  <= 1'b1;
                        state <= HALT;
                    end else if (mem_re || lsu_we) begin
                        state <= MEM;
                    end else begin
                        state <= WB;
                    end
                end
                MEM: begin
                    if (lsu_done) begin
                        state <= WB;
                    end
                end
                WB: begin
                    pc    <= next_pc;
                    state <= FETCH;
                end
                default: begin
                    if (pc_load_first) begin // Setup raised again
                        halt  <= 1'b0;
                        state <= FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            alu_q   <= alu_res;
            taken_q <= alu_taken;
        end
        if (state == WB && reg_we && instr_q.r.rd != 5'd0) begin
            rf[instr_q.r.rd] <= wb_data;
        end
    end

endmodule

/* src/wb_arbiter.sv */
module wb_arbiter (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        m0_cyc, m0_stb, m0_we,
    input  logic [31:0] m0_adr, m0_dat_w,
    input  logic [3:0]  m0_sel,
    output logic        m0_ack,
    output logic [31:0] m0_dat_r,
    input  logic        m1_cyc, m1_stb, m1_we,
    input  logic [31:0] m1_adr, m1_dat_w,
    input  logic [3:0]  m1_sel,
    output logic        m1_ack,
    output logic [31:0] m1_dat_r,
    input  logic        m2_cyc, m2_stb, m2_we,
    input  logic [31:0] m2_adr, m2_dat_w,
    input  logic [3:0]  m2_sel,
    output logic        m2_ack,
    output logic [31:0] m2_dat_r,
    output logic        s_cyc, s_stb, s_we,
    output logic [31:0] s_adr, s_dat_w,
    output logic [3:0]  s_sel,
    input  logic        s_ack,
    input  logic [31:0] s_dat_r
);
    logic [2:0] cyc_vec;
    logic [1:0] grant;
    logic [1:0] owner_q;
    logic       busy_q;

    assign cyc_vec = {m2_cyc, m1_cyc, m0_cyc};

    always_comb begin
        if (busy_q && cyc_vec[owner_q]) begin
            grant = owner_q; // Locked until owner drops cyc
        end else if (m0_cyc) begin
            grant = 2'd0;
        end else if (m1_cyc) begin
            grant = 2'd1;
        end else begin
            grant = 2'd2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner_q <= 2'd0;
            busy_q  <= 1'b0;
        end else begin
            owner_q <= grant;
            busy_q  <= cyc_vec[grant];
        end
    end

    always_comb begin
        case (grant)
            2'd0: {s_cyc, s_stb, s_we, s_adr, s_dat_w, s_sel} =
                  {m0_cyc, m0_stb, m0_we, m0_adr, m0_dat_w, m0_sel};
            2'd1: {s_cyc, s_stb, s_we, s_adr, s_dat_w, s_sel} =
                  {m1_cyc, m1_stb, m1_we, m1_adr, m1_dat_w, m1_sel};
            default: {s_cyc, s_stb, s_we, s_adr, s_dat_w, s_sel} =
                  {m2_cyc, m2_stb, m2_we, m2_adr, m2_dat_w, m2_sel};
        endcase
    end

    assign m0_ack   = s_ack && grant == 2'd0;
    assign m1_ack   = s_ack && grant == 2'd1;
    assign m2_ack   = s_ack && grant == 2'd2;
    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;
    assign m2_dat_r = s_dat_r;

endmodule

/* src/wb_ram.sv */
module wb_ram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        s_cyc,
    input  logic        s_stb,
    input  logic        s_we,
    input  logic [31:0] s_adr,
    input  logic [31:0] s_dat_w,
    input  logic [3:0]  s_sel,
    output logic        s_ack,
    output logic [31:0] s_dat_r
);
    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] idx;
    logic          req;

    assign idx = s_adr[AW+1:2]; // Word address
    assign req = s_cyc & s_stb & ~s_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_ack <= 1'b0;
        end else begin
            s_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (s_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (s_sel[b]) begin
                        mem[idx][8*b +: 8] <= s_dat_w[8*b +: 8];
                    end
                end
            end
            s_dat_r <= mem[idx];
        end
    end

endmodule

/* src/soc_top.sv */
module soc_top #(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] RESET_PC  = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        setup,
    output logic        halt,
    input  logic        host_cyc,
    input  logic        host_stb,
    input  logic        host_we,
    input  logic [31:0] host_adr,
    input  logic [31:0] host_dat_w,
    input  logic [3:0]  host_sel,
    output logic        host_ack,
    output logic [31:0] host_dat_r
);
    import core_ctrl_pkg::*;

    logic        m0_cyc, m0_stb, m0_we, m0_ack;
    logic [31:0] m0_adr, m0_dat_w, m0_dat_r;
    logic [3:0]  m0_sel;
    logic        m1_cyc, m1_stb, m1_we, m1_ack;
    logic [31:0] m1_adr, m1_dat_w, m1_dat_r;
    logic [3:0]  m1_sel;
    logic        s_cyc, s_stb, s_we, s_ack;
    logic [31:0] s_adr, s_dat_w, s_dat_r;
    logic [3:0]  s_sel;

    logic        lsu_start, lsu_we, lsu_signed_ld, lsu_done;
    mem_size_e   lsu_size;
    logic [31:0] lsu_addr, lsu_wdata, lsu_rdata;

    rv_core #(.RESET_PC(RESET_PC)) i_rv_core (.*);

    lsu i_lsu (
        .start     (lsu_start),
        .we        (lsu_we),
        .size      (lsu_size),
        .signed_ld (lsu_signed_ld),
        .addr      (lsu_addr),
        .wdata     (lsu_wdata),
        .rdata     (lsu_rdata),
        .done      (lsu_done),
        .*
    );

    wb_arbiter i_wb_arbiter (
        .m2_cyc   (host_cyc),
        .m2_stb   (host_stb),
        .m2_we    (host_we),
        .m2_adr   (host_adr),
        .m2_dat_w (host_dat_w),
        .m2_sel   (host_sel),
        .m2_ack   (host_ack),
        .m2_dat_r (host_dat_r),
        .*
    );

    wb_ram #(.MEM_WORDS(MEM_WORDS)) i_wb_ram (.*);

endmodule

/* tb/tb_soc.sv */
module tb_soc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string VEC_FILE        = "tb/soc_vectors.txt";
    localparam int    CYCLES_PER_LINE = 200;

    logic        clk;
    logic        arst_n;
    logic        setup;
    logic        halt;
    logic        host_cyc;
    logic        host_stb;
    logic        host_we;
    logic [31:0] host_adr;
    logic [31:0] host_dat_w;
    logic [3:0]  host_sel;
    logic        host_ack;
    logic [31:0] host_dat_r;

    string cmds[$];
    int    errors;
    int    checks;
    int    cycles;
    int    cycle_limit;

    soc_top i_soc_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog armed once the vector file is loaded
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    // Single classic cycle on the host port that returns 1 ns after an edge
    task automatic host_access(input logic we, input logic [31:0] adr,
                               input logic [31:0] data, input logic [3:0] sel,
                               output logic [31:0] rdata);
        @(posedge clk);
        #1;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = adr;
        host_dat_w = data;
        host_sel   = sel;
        do begin
            @(negedge clk);
        end while (!host_ack);
        rdata = host_dat_r; // Valid with ack
        @(posedge clk);
        #1;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_write(input logic [31:0] adr, input logic [31:0] data,
                              input logic [3:0] sel);
        logic [31:0] unused;
        host_access(1'b1, adr, data, sel, unused);
    endtask

    task automatic check_word(input logic [31:0] adr, input logic [31:0] exp);
        logic [31:0] got;
        host_access(1'b0, adr, 32'h0, 4'hF, got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL @%0t: addr 0x%08h read 0x%08h, expected 0x%08h",
                     $time, adr, got, exp);
            errors++;
        end
    endtask

    task automatic wait_halt();
        do begin
            @(negedge clk);
        end while (!halt);
    endtask

    task automatic start_core();
        assert (!halt) else begin
            $display("halt was still high when the core was started");
            errors++;
        end
        @(posedge clk);
        #1;
        setup = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       tok;
        byte         c;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;

        arst_n     = 1'b0;
        setup      = 1'b1;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        host_sel   = '0;
        errors     = 0;
        checks     = 0;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    c = line.getc(0);
                    if (c != "#" && c != "\n" && c != " " && c != 8'd13) begin
                        cmds.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = CYCLES_PER_LINE * cmds.size();

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        foreach (cmds[i]) begin
            c   = cmds[i].getc(0);
            a   = '0;
            d   = '0;
            s   = 32'hF;
            tok = "";
            n = $sscanf(cmds[i].substr(1, cmds[i].len() - 1), "%h %h %s", a, d, tok);
            if (n > 2 && tok.len() == 1) begin
                s = tok.atohex(); // One hex digit after the data is a byte select
            end
            case (c)
                "W": host_write(a, d, s[3:0]);
                "R": check_word(a, d);
                "G": begin
                    start_core();
                    wait_halt();
                end
                "D": start_core(); // Core runs while host keeps going
                "H": wait_halt();
                "S": begin
                    @(posedge clk);
                    #1;
                    setup = 1'b1;
                end
                default: begin
                    $display("Unknown command in the vector file: %s", cmds[i]);
                    errors++;
                end
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Vector lines: %0d, checks: %0d, errors: %0d", cmds.size(), checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb/soc_vectors.txt */
# W addr data [sel] host write | R addr expected host read and compare
# G start and wait for halt | D start only | H wait for halt | S raise setup
W 00000200 11223344
W 00000204 AABBCCDD
W 00000204 00990000 4
R 00000200 11223344
R 00000204 AA99CCDD
# ALU program
W 00000000 06400093 addi x1,x0,100
W 00000004 FF900113 addi x2,x0,-7
W 00000008 002081B3 add x3,x1,x2
W 0000000C 40208233 sub x4,x1,x2
W 00000010 00411293 slli x5,x2,4
W 00000014 00415313 srli x6,x2,4
W 00000018 40415393 srai x7,x2,4
W 0000001C 00112433 slt x8,x2,x1
W 00000020 001134B3 sltu x9,x2,x1
W 00000024 0020C533 xor x10,x1,x2
W 00000028 0020E5B3 or x11,x1,x2
W 0000002C 0020F633 and x12,x1,x2
W 00000030 123456B7 lui x13,0x12345
W 00000034 00001717 auipc x14,1
W 00000038 10302023 sw x3,0x100
W 0000003C 10402223 sw x4,0x104
W 00000040 10502423 sw x5,0x108
W 00000044 10602623 sw x6,0x10c
W 00000048 10702823 sw x7,0x110
W 0000004C 10802A23 sw x8,0x114
W 00000050 10902C23 sw x9,0x118
W 00000054 10A02E23 sw x10,0x11c
W 00000058 12B02023 sw x11,0x120
W 0000005C 12C02223 sw x12,0x124
W 00000060 12D02423 sw x13,0x128
W 00000064 12E02623 sw x14,0x12c
W 00000068 00000073 ecall
D
R 00000200 11223344
H
R 00000100 0000005D
R 00000104 0000006B
R 00000108 FFFFFF90
R 0000010C 0FFFFFFF
R 00000110 FFFFFFFF
R 00000114 00000001
R 00000118 00000000
R 0000011C FFFFFF9D
R 00000120 FFFFFFFD
R 00000124 00000060
R 00000128 12345000
R 0000012C 00001034
S
# Branch, jump and load/store program
W 00000190 DEADBEEF
W 00000000 00500093 addi x1,x0,5
W 00000004 FFD00113 addi x2,x0,-3
W 00000008 00000513 addi x10,x0,0
W 0000000C 00108463 beq x1,x1 taken
W 00000010 04056513 ori x10,0x040
W 00000014 00209463 bne x1,x2 taken
W 00000018 08056513 ori x10,0x080
W 0000001C 00114463 blt x2,x1 taken
W 00000020 10056513 ori x10,0x100
W 00000024 0020D463 bge x1,x2 taken
W 00000028 20056513 ori x10,0x200
W 0000002C 0020E463 bltu x1,x2 taken
W 00000030 40056513 ori x10,0x400
W 00000034 00117463 bgeu x2,x1 taken
W 00000038 80056513 ori x10,-0x800
W 0000003C 00208463 beq x1,x2 not taken
W 00000040 00156513 ori x10,0x001
W 00000044 00109463 bne x1,x1 not taken
W 00000048 00256513 ori x10,0x002
W 0000004C 0020C463 blt x1,x2 not taken
W 00000050 00456513 ori x10,0x004
W 00000054 00115463 bge x2,x1 not taken
W 00000058 00856513 ori x10,0x008
W 0000005C 00116463 bltu x2,x1 not taken
W 00000060 01056513 ori x10,0x010
W 00000064 0020F463 bgeu x1,x2 not taken
W 00000068 02056513 ori x10,0x020
W 0000006C 00C007EF jal x15,+12
W 00000070 7FF56513 ori x10,0x7ff skipped
W 00000074 7FF56513 ori x10,0x7ff skipped
W 00000078 08500893 addi x17,x0,0x85
W 0000007C 00388867 jalr x16,3(x17)
W 00000080 7FF56513 ori x10,0x7ff skipped
W 00000084 7FF56513 ori x10,0x7ff skipped
W 00000088 18A02023 sw x10,0x180
W 0000008C 18F02223 sw x15,0x184
W 00000090 19002423 sw x16,0x188
W 00000094 F8000913 addi x18,x0,-128
W 00000098 000089B7 lui x19,8
W 0000009C 12398993 addi x19,x19,0x123
W 000000A0 192008A3 sb x18,0x191
W 000000A4 19301923 sh x19,0x192
W 000000A8 19100A03 lb x20,0x191
W 000000AC 19104A83 lbu x21,0x191
W 000000B0 19201B03 lh x22,0x192
W 000000B4 19205B83 lhu x23,0x192
W 000000B8 19002C03 lw x24,0x190
W 000000BC 1B402023 sw x20,0x1a0
W 000000C0 1B502223 sw x21,0x1a4
W 000000C4 1B602423 sw x22,0x1a8
W 000000C8 1B702623 sw x23,0x1ac
W 000000CC 1B802823 sw x24,0x1b0
W 000000D0 00000073 ecall
G
R 00000180 0000003F
R 00000184 00000070
R 00000188 00000080
R 00000190 812380EF
R 000001A0 FFFFFF80
R 000001A4 00000080
R 000001A8 FFFF8123
R 000001AC 00008123
R 000001B0 812380EF
R 00000200 11223344

/* project.f */
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/control.sv
src/alu.sv
src/lsu.sv
src/rv_core.sv
src/wb_arbiter.sv
src/wb_ram.sv
src/soc_top.sv
tb/tb_soc.sv

/* Bender.yml */
package:
  name: rv32i_soc

sources:
  - src/rv_isa_pkg.sv
  - src/core_ctrl_pkg.sv
  - src/control.sv
  - src/alu.sv
  - src/lsu.sv
  - src/rv_core.sv
  - src/wb_arbiter.sv
  - src/wb_ram.sv
  - src/soc_top.sv
  - target: test
    files:
      - tb/tb_soc.sv
